// ==== design/trace_pkg.sv ====
package trace_pkg;

    localparam int commit_width   = 2;
    localparam int opid_width     = 5;
    localparam int opid_depth     = 1 << opid_width;
    localparam int xlen           = 64;
    localparam int csr_addr_width = 12;
    localparam int tag_width      = 4;
    localparam int tag_depth      = 1 << tag_width;
    localparam int strb_width     = 8;
    localparam int count_width    = 32;

    // supervisor aliases of machine csrs, moved up by s_alias_offset
    localparam logic [csr_addr_width-1:0] csr_sstatus     = 12'h100;
    localparam logic [csr_addr_width-1:0] csr_sie         = 12'h104;
    localparam logic [csr_addr_width-1:0] csr_sip         = 12'h144;
    localparam logic [csr_addr_width-1:0] s_alias_offset  = 12'h200;
    // user counters cycle..instret map down onto mcycle..minstret
    localparam logic [csr_addr_width-1:0] csr_cycle       = 12'hc00;
    localparam logic [csr_addr_width-1:0] csr_instret     = 12'hc02;
    localparam logic [csr_addr_width-1:0] u_counter_offset = 12'h100;

    typedef logic [opid_width-1:0]  opid_t;
    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [count_width-1:0] count_t;

    typedef enum logic [1:0] {
        kind_branch = 2'd0,
        kind_jal    = 2'd1,
        kind_jalr   = 2'd2,
        kind_other  = 2'd3
    } mispredict_kind_e;

    typedef struct packed {
        logic [xlen-1:0] mstatus;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mepc;
    } csr_state_t;

    typedef struct packed {
        logic  valid;
        opid_t opid;
    } decode_slot_t;

    typedef struct packed {
        logic            valid;
        opid_t           opid;
        logic [xlen-1:0] pc;
        logic [31:0]     ir;
        logic [5:0]      rd;
    } commit_slot_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     ir;
        logic            gpr_write;
        logic [5:0]      rd;
    } commit_report_t;

    typedef struct packed {
        logic                      we;
        logic [csr_addr_width-1:0] addr;
        logic [xlen-1:0]           value;
    } csr_write_t;

    typedef struct packed {
        logic                  valid;
        logic                  is_store;
        tag_t                  tag;
        logic [xlen-1:0]       addr;
        logic [xlen-1:0]       wdata;
        logic [strb_width-1:0] strb;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        logic is_store;
        tag_t tag;
        logic miss;
    } mem_resp_t;

    typedef struct packed {
        logic [7:0]      size;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] value;
    } mem_delta_t;

    typedef struct packed {
        logic             mispredict;
        mispredict_kind_e mispredict_kind;
        logic             front_redirect;
        logic             icache_miss;
        logic             dcache_miss;
        logic             itlb_fill;
        logic             dtlb_fill;
        logic             ldck_valid;
        logic [1:0]       ldck_result;
        logic             ld_forwarded;
        logic             ld_retry;
    } perf_event_t;

    typedef struct packed {
        count_t bmisp;
        count_t fmisp;
        count_t brmisp;
        count_t jmisp;
        count_t jrmisp;
        count_t icmiss;
        count_t dcmiss;
        count_t itmiss;
        count_t dtmiss;
        count_t loads;
        count_t stores;
        count_t ldck1;
        count_t ldck2;
        count_t ldck3;
        count_t ldfwd;
        count_t ldmisp;
    } perf_counts_t;

endpackage

// ==== design/csr_snapshot_table.sv ====
`timescale 1ns/1ps

module csr_snapshot_table (
    input  logic                                                  clk,
    input  trace_pkg::decode_slot_t [trace_pkg::commit_width-1:0] decode,
    input  trace_pkg::csr_state_t                                 csr_now,
    input  trace_pkg::opid_t                                      read_opid,
    output trace_pkg::csr_state_t                                 csr_at_commit
);
    import trace_pkg::*;

    // one csr snapshot per in-flight operation
    csr_state_t snap_mem [opid_depth];

    // every decoded op records the csr state it will execute under
    always_ff @(posedge clk) begin
        for (int i = 0; i < commit_width; i++) begin
            if (decode[i].valid) begin
                snap_mem[decode[i].opid] <= csr_now; // state before the op runs
            end
        end
    end

    // asynchronous read, visible the cycle after decode
    assign csr_at_commit = snap_mem[read_opid];

    // the rename stage hands out unique ids, so slots in one decode group
    // never collide; a collision would leave the later slot's entry ambiguous
    for (genvar i = 0; i < commit_width; i++) begin : g_slot_a
        for (genvar j = i + 1; j < commit_width; j++) begin : g_slot_b
            a_distinct_opid : assert property (@(posedge clk)
                decode[i].valid && decode[j].valid |-> decode[i].opid != decode[j].opid)
                else $error("decode slots %0d and %0d share opid %0h", i, j, decode[i].opid);
        end
    end

endmodule

// ==== design/commit_reporter.sv ====
`timescale 1ns/1ps

module commit_reporter (
    input  trace_pkg::commit_slot_t   [trace_pkg::commit_width-1:0] commit,
    input  trace_pkg::csr_write_t                                   csr_write,
    output trace_pkg::commit_report_t [trace_pkg::commit_width-1:0] reports,
    output trace_pkg::csr_write_t                                   csr_delta
);
    import trace_pkg::*;

    logic is_s_alias;  // sstatus, sie or sip
    logic is_u_counter; // cycle, time or instret

    // per-slot commit report
    always_comb begin
        for (int i = 0; i < commit_width; i++) begin
            reports[i].valid     = commit[i].valid;
            reports[i].pc        = commit[i].pc;
            reports[i].ir        = commit[i].ir;
            reports[i].rd        = commit[i].rd;
            reports[i].gpr_write = |commit[i].rd; // x0 writes are not reported
        end
    end

    assign is_s_alias = (csr_write.addr == csr_sstatus) ||
                        (csr_write.addr == csr_sie) ||
                        (csr_write.addr == csr_sip);

    assign is_u_counter = (csr_write.addr >= csr_cycle) &&
                          (csr_write.addr <= csr_instret);

    // csr write delta, reported under the machine-level name
    always_comb begin
        csr_delta = csr_write;
        if (is_s_alias) begin
            csr_delta.addr = csr_write.addr + s_alias_offset; // 0x1xx -> 0x3xx
        end else if (is_u_counter) begin
            csr_delta.addr = csr_write.addr - u_counter_offset; // 0xc0x -> 0xb0x
        end
    end

endmodule

// ==== design/store_tracker.sv ====
`timescale 1ns/1ps

module store_tracker (
    input  logic                  clk,
    input  trace_pkg::mem_req_t   mem_req,
    input  trace_pkg::mem_resp_t  mem_resp,
    output trace_pkg::mem_delta_t mem_delta
);
    import trace_pkg::*;

    localparam int offset_width = $clog2(strb_width);
    localparam int shamt_width  = $clog2(xlen);

    mem_delta_t                  st_mem [tag_depth]; // pending store per tag
    mem_delta_t                  st_entry;
    logic [offset_width-1:0]     st_offset;          // lowest enabled byte lane
    logic [shamt_width-1:0]      st_shamt;
    logic                        st_capture;
    logic                        st_commit;

    // scan downward so the lowest set strobe wins
    always_comb begin
        st_offset = '0;
        for (int i = strb_width - 1; i >= 0; i--) begin
            if (mem_req.strb[i]) begin
                st_offset = offset_width'(i);
            end
        end
    end

    assign st_shamt   = {st_offset, 3'b000}; // bytes to bits
    assign st_capture = mem_req.valid && mem_req.is_store;

    // store data is kept right-aligned to its first byte
    always_ff @(posedge clk) begin
        if (st_capture) begin
            st_mem[mem_req.tag].addr  <= mem_req.addr;
            st_mem[mem_req.tag].value <= mem_req.wdata >> st_shamt;
            st_mem[mem_req.tag].size  <= 8'($countones(mem_req.strb));
        end
    end

    assign st_entry  = st_mem[mem_resp.tag];
    assign st_commit = mem_resp.valid && mem_resp.is_store && !mem_resp.miss;

    // memory change is only real when the store hits
    always_comb begin
        mem_delta       = st_entry;
        mem_delta.size  = st_commit ? st_entry.size : 8'd0;
    end

    // the lsu never issues a store without at least one enabled byte
    a_store_strb : assert property (@(posedge clk)
        st_capture |-> mem_req.strb != '0)
        else $error("store request on tag %0h with empty strobe", mem_req.tag);

endmodule

// ==== design/perf_counters.sv ====
`timescale 1ns/1ps

module perf_counters (
    input  logic                    clk,
    input  logic                    rst,
    input  trace_pkg::mem_resp_t    mem_resp,
    input  trace_pkg::perf_event_t  perf_event,
    output trace_pkg::perf_counts_t counts
);
    import trace_pkg::*;

    localparam count_t one = count_t'(1);

    // mispredict counters; back-end redirects hide front-end ones
    always_ff @(posedge clk) begin
        if (rst) begin
            counts.bmisp  <= '0;
            counts.fmisp  <= '0;
            counts.brmisp <= '0;
            counts.jmisp  <= '0;
            counts.jrmisp <= '0;
        end else if (perf_event.mispredict) begin
            counts.bmisp <= counts.bmisp + one;
            case (perf_event.mispredict_kind)
                kind_branch: counts.brmisp <= counts.brmisp + one;
                kind_jal:    counts.jmisp  <= counts.jmisp + one;
                kind_jalr:   counts.jrmisp <= counts.jrmisp + one;
                default:     ; // only in bmisp
            endcase
        end else if (perf_event.front_redirect) begin
            counts.fmisp <= counts.fmisp + one;
        end
    end

    // memory traffic, miss or not
    always_ff @(posedge clk) begin
        if (rst) begin
            counts.loads  <= '0;
            counts.stores <= '0;
        end else if (mem_resp.valid) begin
            if (mem_resp.is_store) begin
                counts.stores <= counts.stores + one;
            end else begin
                counts.loads <= counts.loads + one;
            end
        end
    end

    // cache and tlb refills
    always_ff @(posedge clk) begin
        if (rst) begin
            counts.icmiss <= '0;
            counts.dcmiss <= '0;
            counts.itmiss <= '0;
            counts.dtmiss <= '0;
        end else begin
            counts.icmiss <= counts.icmiss + count_t'(perf_event.icache_miss);
            counts.dcmiss <= counts.dcmiss + count_t'(perf_event.dcache_miss);
            counts.itmiss <= counts.itmiss + count_t'(perf_event.itlb_fill);
            counts.dtmiss <= counts.dtmiss + count_t'(perf_event.dtlb_fill);
        end
    end

    // load check outcomes
    always_ff @(posedge clk) begin
        if (rst) begin
            counts.ldck1  <= '0;
            counts.ldck2  <= '0;
            counts.ldck3  <= '0;
            counts.ldfwd  <= '0;
            counts.ldmisp <= '0;
        end else begin
            if (perf_event.ldck_valid) begin
                case (perf_event.ldck_result)
                    2'd1:    counts.ldck1 <= counts.ldck1 + one;
                    2'd2:    counts.ldck2 <= counts.ldck2 + one;
                    2'd3:    counts.ldck3 <= counts.ldck3 + one;
                    default: ; // clean check
                endcase
                if (perf_event.ld_forwarded) begin
                    counts.ldfwd <= counts.ldfwd + one;
                end
            end
            if (perf_event.ld_retry) begin
                counts.ldmisp <= counts.ldmisp + one;
            end
        end
    end

    // result lines are only meaningful alongside ldck_valid
    a_ldck_idle : assert property (@(posedge clk) disable iff (rst)
        !perf_event.ldck_valid |-> perf_event.ldck_result == 2'd0)
        else $error("ldck_result %0d without ldck_valid", perf_event.ldck_result);

endmodule

// ==== design/core_trace_top.sv ====
`timescale 1ns/1ps

module core_trace_top (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  trace_pkg::decode_slot_t   [trace_pkg::commit_width-1:0] decode,
    input  trace_pkg::csr_state_t                                   csr_now,
    input  trace_pkg::commit_slot_t   [trace_pkg::commit_width-1:0] commit,
    input  trace_pkg::csr_write_t                                   csr_write,
    input  trace_pkg::mem_req_t                                     mem_req,
    input  trace_pkg::mem_resp_t                                    mem_resp,
    input  trace_pkg::perf_event_t                                  perf_event,
    output trace_pkg::commit_report_t [trace_pkg::commit_width-1:0] reports,
    output trace_pkg::csr_state_t                                   csr_at_commit,
    output trace_pkg::csr_write_t                                   csr_delta,
    output trace_pkg::mem_delta_t                                   mem_delta,
    output trace_pkg::perf_counts_t                                 counts
);

    // snapshots are looked up by the oldest committing op
    csr_snapshot_table u_snapshot (
        .clk           (clk),
        .decode        (decode),
        .csr_now       (csr_now),
        .read_opid     (commit[0].opid),
        .csr_at_commit (csr_at_commit)
    );

    commit_reporter u_reporter (
        .commit    (commit),
        .csr_write (csr_write),
        .reports   (reports),
        .csr_delta (csr_delta)
    );

    store_tracker u_store (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .mem_delta (mem_delta)
    );

    perf_counters u_perf (
        .clk        (clk),
        .rst        (rst),
        .mem_resp   (mem_resp),
        .perf_event (perf_event),
        .counts     (counts)
    );

endmodule

// ==== verification/tb_trace_model.svh ====
`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

// name a csr write is reported under
function automatic logic [11:0] expected_alias(input logic [11:0] addr);
    case (addr)
        12'h100: return 12'h300; // sstatus
        12'h104: return 12'h304; // sie
        12'h144: return 12'h344; // sip
        12'hc00: return 12'hb00; // cycle
        12'hc01: return 12'hb01; // time
        12'hc02: return 12'hb02; // instret
        default: return addr;
    endcase
endfunction

// delta for a remembered store request, size only on a hit
function automatic mem_delta_t expected_store_delta(input mem_req_t req, input logic hit);
    mem_delta_t d;
    int         first;
    int         n;
    first   = -1;
    n       = 0;
    d.addr  = req.addr;
    d.value = '0;
    for (int b = 0; b < 8; b++) begin
        if (req.strb[b]) begin
            n++;
            if (first < 0) begin
                first = b;
            end
        end
    end
    for (int b = first; b < 8; b++) begin
        d.value[(b - first) * 8 +: 8] = req.wdata[b * 8 +: 8]; // byte moves down to lane 0
    end
    d.size = hit ? 8'(n) : 8'd0;
    return d;
endfunction

// counter values one cycle after the given strobes
function automatic perf_counts_t next_counts(input perf_counts_t c, input perf_event_t ev,
                                             input mem_resp_t resp);
    perf_counts_t n;
    n = c;
    if (ev.mispredict) begin
        n.bmisp = c.bmisp + 1;
        if (ev.mispredict_kind == kind_branch) n.brmisp = c.brmisp + 1;
        if (ev.mispredict_kind == kind_jal)    n.jmisp  = c.jmisp + 1;
        if (ev.mispredict_kind == kind_jalr)   n.jrmisp = c.jrmisp + 1;
    end else if (ev.front_redirect) begin
        n.fmisp = c.fmisp + 1; // front end only counts when the back end is quiet
    end
    if (resp.valid && resp.is_store)  n.stores = c.stores + 1;
    if (resp.valid && !resp.is_store) n.loads  = c.loads + 1;
    if (ev.icache_miss) n.icmiss = c.icmiss + 1;
    if (ev.dcache_miss) n.dcmiss = c.dcmiss + 1;
    if (ev.itlb_fill)   n.itmiss = c.itmiss + 1;
    if (ev.dtlb_fill)   n.dtmiss = c.dtmiss + 1;
    if (ev.ldck_valid && ev.ldck_result == 2'd1) n.ldck1 = c.ldck1 + 1;
    if (ev.ldck_valid && ev.ldck_result == 2'd2) n.ldck2 = c.ldck2 + 1;
    if (ev.ldck_valid && ev.ldck_result == 2'd3) n.ldck3 = c.ldck3 + 1;
    if (ev.ldck_valid && ev.ld_forwarded)        n.ldfwd = c.ldfwd + 1;
    if (ev.ld_retry) n.ldmisp = c.ldmisp + 1;
    return n;
endfunction

`endif

// ==== verification/tb_core_trace.sv ====
`timescale 1ns/1ps

module tb_core_trace;
    import trace_pkg::*;

    `include "tb_trace_model.svh"

    localparam int reset_cycles = 8;
    localparam int snap_cycles  = 40;
    localparam int alias_cycles = 60;
    localparam int store_rounds = 3;
    localparam int event_cycles = 200;
    localparam int n_counters   = $bits(perf_counts_t) / count_width;
    // decode, commit, alias, store fill and response, two event runs
    localparam int total_cycles = reset_cycles + snap_cycles + opid_depth + alias_cycles
                                  + store_rounds * 2 * tag_depth + 2 * event_cycles + 20;

    logic                                clk;
    logic                                rst;
    decode_slot_t   [commit_width-1:0]   decode;
    csr_state_t                          csr_now;
    commit_slot_t   [commit_width-1:0]   commit;
    csr_write_t                          csr_write;
    mem_req_t                            mem_req;
    mem_resp_t                           mem_resp;
    perf_event_t                         perf_event;
    commit_report_t [commit_width-1:0]   reports;
    csr_state_t                          csr_at_commit;
    csr_write_t                          csr_delta;
    mem_delta_t                          mem_delta;
    perf_counts_t                        counts;
    perf_counts_t                        model_counts;
    logic [n_counters-1:0][count_width-1:0] exp_flat;
    logic [n_counters-1:0][count_width-1:0] act_flat;
    int   error_count;
    int   check_count;
    int   test_errors;     // error count when the running test began
    logic counts_check_on;
    string counter_names [n_counters] = '{"ldmisp", "ldfwd", "ldck3", "ldck2", "ldck1",
        "stores", "loads", "dtmiss", "itmiss", "dcmiss", "icmiss", "jrmisp", "jmisp",
        "brmisp", "fmisp", "bmisp"};

    core_trace_top u_dut (.*);

    assign exp_flat = model_counts;
    assign act_flat = counts;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(total_cycles * 100 + 2000);
        $display("watchdog expired, tests did not complete within %0d cycles", total_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    always @(posedge clk) begin
        if (rst) begin
            model_counts <= '0;
        end else begin
            model_counts <= next_counts(model_counts, perf_event, mem_resp);
        end
    end

    always @(negedge clk) begin
        if (counts_check_on) begin
            for (int i = 0; i < n_counters; i++) begin
                check_value(counter_names[i], 64'(exp_flat[i]), 64'(act_flat[i]));
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // reports copy the committing slots, gpr_write only for a nonzero rd
    task automatic check_reports();
        string prefix;
        for (int s = 0; s < commit_width; s++) begin
            prefix = $sformatf("reports[%0d]", s);
            check_value({prefix, ".valid"}, 64'(commit[s].valid), 64'(reports[s].valid));
            check_value({prefix, ".pc"}, commit[s].pc, reports[s].pc);
            check_value({prefix, ".ir"}, 64'(commit[s].ir), 64'(reports[s].ir));
            check_value({prefix, ".rd"}, 64'(commit[s].rd), 64'(reports[s].rd));
            check_value({prefix, ".gpr_write"}, 64'(commit[s].rd != 6'd0),
                        64'(reports[s].gpr_write));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #10; // inputs change well clear of the edge
    endtask

    function automatic logic [xlen-1:0] random_word();
        return {$urandom, $urandom};
    endfunction

    task automatic end_test(input string name);
        $display("test %-9s done, %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    task automatic test_snapshot();
        csr_state_t            snap_model [opid_depth];
        logic [opid_depth-1:0] written;
        written = '0;
        for (int n = 0; n < snap_cycles; n++) begin
            step();
            csr_now.mstatus = random_word();
            csr_now.mtvec   = random_word();
            csr_now.mcause  = random_word();
            csr_now.mepc    = random_word();
            decode[0].opid  = opid_t'($urandom);
            decode[1].opid  = decode[0].opid + opid_t'(1 + $urandom % (opid_depth - 1));
            for (int s = 0; s < commit_width; s++) begin
                decode[s].valid = ($urandom % 4 != 0);
                if (decode[s].valid) begin
                    snap_model[decode[s].opid] = csr_now;
                    written[decode[s].opid]    = 1'b1;
                end
            end
        end
        step();
        decode = '0;
        for (int id = 0; id < opid_depth; id++) begin
            if (written[id]) begin
                commit[0].valid = 1'b1;
                commit[0].opid  = opid_t'(id);
                commit[0].pc    = random_word();
                commit[0].ir    = $urandom;
                commit[0].rd    = ($urandom % 4 == 0) ? 6'd0 : 6'($urandom);
                commit[1].valid = 1'($urandom);
                commit[1].opid  = opid_t'($urandom);
                commit[1].pc    = random_word();
                commit[1].ir    = $urandom;
                commit[1].rd    = ($urandom % 4 == 0) ? 6'd0 : 6'($urandom);
                @(negedge clk);
                check_value("csr_at_commit.mstatus", snap_model[id].mstatus, csr_at_commit.mstatus);
                check_value("csr_at_commit.mtvec", snap_model[id].mtvec, csr_at_commit.mtvec);
                check_value("csr_at_commit.mcause", snap_model[id].mcause, csr_at_commit.mcause);
                check_value("csr_at_commit.mepc", snap_model[id].mepc, csr_at_commit.mepc);
                check_reports();
                step();
            end
        end
        commit = '0;
    endtask

    task automatic test_alias();
        logic [csr_addr_width-1:0] listed [10] = '{12'h100, 12'h104, 12'h144, 12'hc00,
            12'hc01, 12'hc02, 12'h300, 12'hc03, 12'h0ff, 12'h143};
        for (int n = 0; n < alias_cycles; n++) begin
            step();
            if (n < 10) begin
                csr_write.addr = listed[n];
            end else begin
                csr_write.addr = csr_addr_width'($urandom);
            end
            csr_write.we    = 1'($urandom);
            csr_write.value = random_word();
            @(negedge clk);
            check_value("csr_delta.we", 64'(csr_write.we), 64'(csr_delta.we));
            check_value("csr_delta.addr", 64'(expected_alias(csr_write.addr)),
                        64'(csr_delta.addr));
            check_value("csr_delta.value", csr_write.value, csr_delta.value);
        end
        step();
        csr_write = '0;
    endtask

    task automatic test_store();
        mem_req_t   reqs [tag_depth];
        mem_delta_t exp;
        tag_t       tag;
        for (int r = 0; r < store_rounds; r++) begin
            for (int t = 0; t < tag_depth; t++) begin // every tag gets a fresh store
                step();
                mem_resp         = '0;
                mem_req.valid    = 1'b1;
                mem_req.is_store = 1'b1;
                mem_req.tag      = tag_t'(t);
                mem_req.addr     = random_word();
                mem_req.wdata    = random_word();
                mem_req.strb     = 8'($urandom);
                if (mem_req.strb == '0) begin
                    mem_req.strb = 8'h80;
                end
                reqs[t] = mem_req;
            end
            for (int n = 0; n < tag_depth; n++) begin
                step();
                mem_req           = '0;
                tag               = tag_t'($urandom);
                mem_resp.valid    = 1'b1;
                mem_resp.is_store = ($urandom % 4 != 0);
                mem_resp.tag      = tag;
                mem_resp.miss     = ($urandom % 3 == 0);
                exp = expected_store_delta(reqs[tag], mem_resp.is_store && !mem_resp.miss);
                @(negedge clk);
                check_value("mem_delta.size", 64'(exp.size), 64'(mem_delta.size));
                check_value("mem_delta.addr", exp.addr, mem_delta.addr);
                check_value("mem_delta.value", exp.value, mem_delta.value);
            end
        end
        step();
        mem_resp = '0;
    endtask

    // full adds memory, refill and load-check strobes to the mispredicts
    task automatic test_events(input logic full);
        for (int n = 0; n < event_cycles; n++) begin
            step();
            perf_event                 = '0;
            mem_resp                   = '0;
            perf_event.mispredict      = 1'($urandom);
            perf_event.mispredict_kind = mispredict_kind_e'(2'($urandom));
            perf_event.front_redirect  = 1'($urandom);
            if (full) begin
                perf_event.icache_miss  = 1'($urandom);
                perf_event.dcache_miss  = 1'($urandom);
                perf_event.itlb_fill    = 1'($urandom);
                perf_event.dtlb_fill    = 1'($urandom);
                perf_event.ldck_valid   = 1'($urandom);
                perf_event.ldck_result  = perf_event.ldck_valid ? 2'($urandom) : 2'd0;
                perf_event.ld_forwarded = 1'($urandom);
                perf_event.ld_retry     = 1'($urandom);
                mem_resp.valid          = 1'($urandom);
                mem_resp.is_store       = 1'($urandom);
                mem_resp.tag            = tag_t'($urandom);
                mem_resp.miss           = 1'($urandom);
            end
        end
        step();
        perf_event = '0;
        mem_resp   = '0;
    endtask

    initial begin
        void'($urandom(28726));
        error_count     = 0;
        check_count     = 0;
        test_errors     = 0;
        counts_check_on = 1'b0;
        rst             = 1'b1;
        decode          = '0;
        csr_now         = '0;
        commit          = '0;
        csr_write       = '0;
        mem_req         = '0;
        mem_resp        = '0;
        perf_event      = '0;
        repeat (reset_cycles) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < n_counters; i++) begin
            check_value(counter_names[i], 64'd0, 64'(act_flat[i]));
        end
        end_test("reset");
        counts_check_on = 1'b1; // counters are compared every cycle from here on
        test_snapshot();
        end_test("snapshot");
        test_alias();
        end_test("alias");
        test_store();
        end_test("store");
        test_events(1'b0);
        end_test("mispredict");
        test_events(1'b1);
        end_test("counters");
        @(negedge clk);
        counts_check_on = 1'b0;
        $display("6 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verification
design/trace_pkg.sv
design/csr_snapshot_table.sv
design/commit_reporter.sv
design/store_tracker.sv
design/perf_counters.sv
design/core_trace_top.sv
verification/tb_core_trace.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_core_trace \
    -Mdir obj_dir -o sim_core_trace > build.log 2>&1 \
    && ./obj_dir/sim_core_trace > sim.log 2>&1 \
    || { echo "build or simulation aborted, see build.log and sim.log"; exit 1; }

grep -qx "Simulation finished: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
